//--- hw/dtim_defines.svh
`ifndef DTIM_DEFINES_SVH
`define DTIM_DEFINES_SVH

// Geometry
`define DTIM_DEPTH      64
`define DTIM_WIDTH      4
`define DTIM_SET_BITS   6
`define DTIM_BANK_BITS  2

// Address split and entry layout
`define DTIM_TAG_BITS   (32 - `DTIM_SET_BITS - `DTIM_BANK_BITS - 2)
`define DTIM_ENTRY_BITS (2 + `DTIM_TAG_BITS + 32)

// Cached window, top is exclusive
`define DTIM_BASE_ADDR  32'h0000_0000
`define DTIM_TOP_ADDR   32'h0000_1000

`endif

//--- hw/dtim_pkg.sv
`include "dtim_defines.svh"

package dtim_pkg;

  typedef union packed {
    logic [`DTIM_ENTRY_BITS-1:0] raw;   // As held in the banks
    struct packed {
      logic                      lock;
      logic                      dirty;
      logic [`DTIM_TAG_BITS-1:0] tag;
      logic [31:0]               data;
    } f;
  } dtim_entry_u;

  typedef enum logic [1:0] {
    class_hit,
    class_miss,
    class_bypass,
    class_fence
  } dtim_class_e;

  function automatic logic [31:0] merge_bytes(
    input logic [31:0] base,
    input logic [31:0] store,
    input logic [3:0]  strb
  );
    logic [31:0] merged;
    merged = base;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = store[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

//--- hw/dtim_bank.sv
`timescale 1ns/1ns
`include "dtim_defines.svh"

module dtim_bank #(
  parameter int depth = `DTIM_DEPTH
) (
  input  logic                        clock,
  input  logic                        wr_en,
  input  logic [$clog2(depth)-1:0]    wr_set,
  input  logic [`DTIM_ENTRY_BITS-1:0] wr_data,
  input  logic [$clog2(depth)-1:0]    rd_set,
  output logic [`DTIM_ENTRY_BITS-1:0] rd_data
);

  logic [`DTIM_ENTRY_BITS-1:0] mem [depth] = '{default: '0};
  logic [$clog2(depth)-1:0]    rd_set_q;

  always_ff @(posedge clock) begin
    rd_set_q <= rd_set;               // Registered read address
    if (wr_en) begin
      mem[wr_set] <= wr_data;
    end
  end

  // Same-edge write is visible on the read side
  assign rd_data = mem[rd_set_q];

endmodule

//--- hw/dtim_bank_array.sv
`timescale 1ns/1ns
`include "dtim_defines.svh"

module dtim_bank_array import dtim_pkg::*; (
  input  logic                       clock,
  input  logic [`DTIM_SET_BITS-1:0]  lk_set,
  input  logic [`DTIM_BANK_BITS-1:0] lk_bank,
  input  logic                       fl_rd_en,
  input  logic [`DTIM_SET_BITS-1:0]  fl_set,
  input  logic [`DTIM_BANK_BITS-1:0] fl_bank,
  input  logic                       wr_en,
  input  logic [`DTIM_SET_BITS-1:0]  wr_set,
  input  logic [`DTIM_BANK_BITS-1:0] wr_bank,
  input  dtim_entry_u                wr_entry,
  input  logic                       clr_en,
  output dtim_entry_u                rd_entry
);

  logic [`DTIM_SET_BITS-1:0]   rd_set;
  logic [`DTIM_BANK_BITS-1:0]  rd_bank;
  logic [`DTIM_BANK_BITS-1:0]  rd_bank_q;
  logic [`DTIM_SET_BITS-1:0]   bank_wr_set;
  logic [`DTIM_BANK_BITS-1:0]  bank_wr_sel;
  logic [`DTIM_ENTRY_BITS-1:0] bank_wr_data;
  logic                        bank_wr_any;
  logic [`DTIM_ENTRY_BITS-1:0] bank_rd_data [`DTIM_WIDTH];

  // Flush walker wins both ports
  assign rd_set       = fl_rd_en ? fl_set : lk_set;
  assign rd_bank      = fl_rd_en ? fl_bank : lk_bank;
  assign bank_wr_set  = clr_en ? fl_set : wr_set;
  assign bank_wr_sel  = clr_en ? fl_bank : wr_bank;
  assign bank_wr_data = clr_en ? '0 : wr_entry.raw;
  assign bank_wr_any  = clr_en || wr_en;

  always_ff @(posedge clock) begin
    rd_bank_q <= rd_bank;             // Picks the answering bank
  end

  for (genvar i = 0; i < `DTIM_WIDTH; i++) begin : g_bank
    dtim_bank #(
      .depth (`DTIM_DEPTH)
    ) u_bank (
      .clock   (clock),
      .wr_en   (bank_wr_any && bank_wr_sel == `DTIM_BANK_BITS'(i)),
      .wr_set  (bank_wr_set),
      .wr_data (bank_wr_data),
      .rd_set  (rd_bank == `DTIM_BANK_BITS'(i) ? rd_set : '0),
      .rd_data (bank_rd_data[i])
    );
  end

  assign rd_entry.raw = bank_rd_data[rd_bank_q];

endmodule

//--- hw/dtim_req_stage.sv
`timescale 1ns/1ns
`include "dtim_defines.svh"

module dtim_req_stage import dtim_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       req_valid,
  input  logic                       req_fence,
  input  logic [31:0]                req_addr,
  input  logic [31:0]                req_wdata,
  input  logic [3:0]                 req_wstrb,
  output logic [`DTIM_SET_BITS-1:0]  lk_set,
  output logic [`DTIM_BANK_BITS-1:0] lk_bank,
  output logic                       r_valid,
  output logic                       r_fence,
  output logic [31:0]                r_addr,
  output logic [`DTIM_TAG_BITS-1:0]  r_tag,
  output logic [`DTIM_SET_BITS-1:0]  r_set,
  output logic [`DTIM_BANK_BITS-1:0] r_bank,
  output logic [31:0]                r_wdata,
  output logic [3:0]                 r_wstrb
);

  localparam int bank_lo = 2;
  localparam int set_lo  = bank_lo + `DTIM_BANK_BITS;
  localparam int tag_lo  = set_lo + `DTIM_SET_BITS;

  logic [31:0] word_addr;

  assign word_addr = {req_addr[31:2], 2'b00};
  assign lk_set    = word_addr[set_lo +: `DTIM_SET_BITS];   // Early read, same cycle
  assign lk_bank   = word_addr[bank_lo +: `DTIM_BANK_BITS];

  always_ff @(posedge clock) begin
    if (!reset) begin
      r_valid <= 1'b0;
      r_fence <= 1'b0;
    end else begin
      r_valid <= req_valid;
      r_fence <= req_valid && req_fence;
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid) begin
      r_addr  <= word_addr;
      r_tag   <= word_addr[tag_lo +: `DTIM_TAG_BITS];
      r_set   <= lk_set;
      r_bank  <= lk_bank;
      r_wdata <= req_wdata;
      r_wstrb <= req_wstrb;
    end
  end

endmodule

//--- hw/dtim_lookup.sv
`timescale 1ns/1ns
`include "dtim_defines.svh"

module dtim_lookup import dtim_pkg::*; (
  input  logic                      r_fence,
  input  logic [31:0]               r_addr,
  input  logic [`DTIM_TAG_BITS-1:0] r_tag,
  input  logic [31:0]               r_wdata,
  input  logic [3:0]                r_wstrb,
  input  dtim_entry_u               rd_entry,
  output dtim_class_e               cls,
  output logic [31:0]               hit_rdata,
  output dtim_entry_u               hit_entry
);

  logic in_window;

  // One unsigned compare covers both bounds
  assign in_window = (r_addr - `DTIM_BASE_ADDR) < (`DTIM_TOP_ADDR - `DTIM_BASE_ADDR);

  always_comb begin
    if (r_fence) begin
      cls = class_fence;
    end else if (!in_window) begin
      cls = class_bypass;
    end else if (!rd_entry.f.lock) begin
      cls = class_miss;
    end else if (rd_entry.f.tag != r_tag) begin
      cls = class_bypass;               // Line held by another tag
    end else begin
      cls = class_hit;
    end
  end

  assign hit_rdata = (|r_wstrb) ? '0 : rd_entry.f.data;   // Stores answer zero

  always_comb begin
    hit_entry.f.lock  = 1'b1;
    hit_entry.f.dirty = 1'b1;
    hit_entry.f.tag   = r_tag;
    hit_entry.f.data  = merge_bytes(rd_entry.f.data, r_wdata, r_wstrb);
  end

endmodule

//--- hw/dtim_flush_walker.sv
`timescale 1ns/1ns
`include "dtim_defines.svh"

module dtim_flush_walker import dtim_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush_start,
  input  logic                       mem_ready,
  output logic                       fl_rd_en,
  output logic [`DTIM_SET_BITS-1:0]  fl_set,
  output logic [`DTIM_BANK_BITS-1:0] fl_bank,
  output logic                       clr_en,
  input  dtim_entry_u                rd_entry,
  output logic                       wb_valid,
  output logic [31:0]                wb_addr,
  output logic [31:0]                wb_data,
  output logic                       flush_done
);

  localparam int line_bits = `DTIM_SET_BITS + `DTIM_BANK_BITS;

  localparam logic [1:0] w_idle  = 2'd0;
  localparam logic [1:0] w_read  = 2'd1;
  localparam logic [1:0] w_clear = 2'd2;
  localparam logic [1:0] w_wait  = 2'd3;

  logic [1:0]           state;
  logic [line_bits-1:0] line_q;
  logic                 dirty_line;
  logic                 last_line;
  logic                 step;

  assign {fl_set, fl_bank} = line_q;    // Bank bits lowest, so bank steps first

  assign dirty_line = rd_entry.f.lock && rd_entry.f.dirty;
  assign last_line  = &line_q;
  assign fl_rd_en   = state == w_read;
  assign clr_en     = state == w_clear;
  assign wb_valid   = clr_en && dirty_line;
  assign wb_addr    = {rd_entry.f.tag, fl_set, fl_bank, 2'b00};
  assign wb_data    = rd_entry.f.data;

  // Line done, clean now or after its write-back returns
  assign step       = (clr_en && !dirty_line) || (state == w_wait && mem_ready);
  assign flush_done = step && last_line;

  // ##################################################
  always_ff @(posedge clock) begin
    if (!reset) begin
      state  <= w_idle;
      line_q <= '0;
    end else begin
      case (state)
        w_idle: begin
          if (flush_start) begin
            state <= w_read;          // Counter already back at line zero
          end
        end
        w_read: begin
          state <= w_clear;
        end
        w_clear: begin
          if (dirty_line) begin
            state <= w_wait;
          end
        end
        default: begin
        end
      endcase
      if (step) begin
        line_q <= line_q + line_bits'(1);
        state  <= last_line ? w_idle : w_read;
      end
    end
  end

endmodule

//--- hw/dtim_fsm.sv
`timescale 1ns/1ns
`include "dtim_defines.svh"

module dtim_fsm import dtim_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       r_valid,
  input  logic [31:0]                r_addr,
  input  logic [`DTIM_SET_BITS-1:0]  r_set,
  input  logic [`DTIM_BANK_BITS-1:0] r_bank,
  input  logic [`DTIM_TAG_BITS-1:0]  r_tag,
  input  logic [31:0]                r_wdata,
  input  logic [3:0]                 r_wstrb,
  input  dtim_class_e                cls,
  input  logic [31:0]                hit_rdata,
  input  dtim_entry_u                hit_entry,
  input  logic                       wb_valid,
  input  logic [31:0]                wb_addr,
  input  logic [31:0]                wb_data,
  input  logic                       flush_done,
  output logic                       flush_start,
  output logic                       wr_en,
  output logic [`DTIM_SET_BITS-1:0]  wr_set,
  output logic [`DTIM_BANK_BITS-1:0] wr_bank,
  output dtim_entry_u                wr_entry,
  output logic                       mem_valid,
  output logic [31:0]                mem_addr,
  output logic [31:0]                mem_wdata,
  output logic [3:0]                 mem_wstrb,
  input  logic                       mem_ready,
  input  logic [31:0]                mem_rdata,
  output logic                       resp_ready,
  output logic [31:0]                resp_rdata
);

  localparam logic [1:0] s_idle   = 2'd0;
  localparam logic [1:0] s_miss   = 2'd1;
  localparam logic [1:0] s_bypass = 2'd2;
  localparam logic [1:0] s_fence  = 2'd3;

  logic [1:0]  state;
  logic        start;
  logic [31:0] st_data;
  logic [3:0]  st_strb;
  dtim_entry_u fill_entry;

  assign start       = state == s_idle && r_valid;
  assign flush_start = start && cls == class_fence;

  // ##################################################
  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: begin
          if (r_valid) begin
            case (cls)
              class_miss:   state <= s_miss;
              class_bypass: state <= s_bypass;
              class_fence:  state <= s_fence;
              default:      state <= s_idle;
            endcase
          end
        end
        s_miss, s_bypass: begin
          if (mem_ready) begin
            state <= s_idle;
          end
        end
        default: begin
          if (flush_done) begin
            state <= s_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start && cls == class_miss) begin
      st_data <= r_wdata;             // Merged into the fetched word
      st_strb <= r_wstrb;
    end
  end

  // ##################################################
  always_comb begin
    fill_entry.f.lock  = 1'b1;
    fill_entry.f.dirty = |st_strb;
    fill_entry.f.tag   = r_tag;
    fill_entry.f.data  = merge_bytes(mem_rdata, st_data, st_strb);
  end

  assign wr_set  = r_set;
  assign wr_bank = r_bank;

  always_comb begin
    if (state == s_miss) begin
      wr_en    = mem_ready;
      wr_entry = fill_entry;
    end else begin
      wr_en    = start && cls == class_hit && |r_wstrb;
      wr_entry = hit_entry;
    end
  end

  // ##################################################
  always_comb begin
    mem_valid = 1'b0;
    mem_addr  = r_addr;
    mem_wdata = r_wdata;
    mem_wstrb = r_wstrb;
    if (state == s_fence) begin
      mem_valid = wb_valid;
      mem_addr  = wb_addr;
      mem_wdata = wb_data;
      mem_wstrb = 4'hf;               // Whole line goes back
    end else if (start && cls == class_miss) begin
      mem_valid = 1'b1;
      mem_wstrb = 4'h0;               // Fill is a plain load
    end else if (start && cls == class_bypass) begin
      mem_valid = 1'b1;
    end
  end

  always_comb begin
    resp_ready = 1'b0;
    resp_rdata = mem_rdata;
    case (state)
      s_idle: begin
        resp_ready = r_valid && cls == class_hit;
        resp_rdata = hit_rdata;
      end
      s_miss, s_bypass: begin
        resp_ready = mem_ready;
      end
      default: begin
        resp_ready = flush_done;
        resp_rdata = '0;
      end
    endcase
  end

endmodule

//--- hw/dtim.sv
`timescale 1ns/1ns
`include "dtim_defines.svh"

module dtim import dtim_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  input  logic        req_fence,
  input  logic [31:0] req_addr,
  input  logic [31:0] req_wdata,
  input  logic [3:0]  req_wstrb,
  output logic        resp_ready,
  output logic [31:0] resp_rdata,
  output logic        mem_valid,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  output logic [3:0]  mem_wstrb,
  input  logic        mem_ready,
  input  logic [31:0] mem_rdata
);

  // Request stage
  logic [`DTIM_SET_BITS-1:0]  lk_set;
  logic [`DTIM_BANK_BITS-1:0] lk_bank;
  logic                       r_valid;
  logic                       r_fence;
  logic [31:0]                r_addr;
  logic [`DTIM_TAG_BITS-1:0]  r_tag;
  logic [`DTIM_SET_BITS-1:0]  r_set;
  logic [`DTIM_BANK_BITS-1:0] r_bank;
  logic [31:0]                r_wdata;
  logic [3:0]                 r_wstrb;

  // Lookup and bank ports
  dtim_entry_u                rd_entry;
  dtim_class_e                cls;
  logic [31:0]                hit_rdata;
  dtim_entry_u                hit_entry;
  logic                       wr_en;
  logic [`DTIM_SET_BITS-1:0]  wr_set;
  logic [`DTIM_BANK_BITS-1:0] wr_bank;
  dtim_entry_u                wr_entry;

  // Fence walk
  logic                       flush_start;
  logic                       flush_done;
  logic                       fl_rd_en;
  logic [`DTIM_SET_BITS-1:0]  fl_set;
  logic [`DTIM_BANK_BITS-1:0] fl_bank;
  logic                       clr_en;
  logic                       wb_valid;
  logic [31:0]                wb_addr;
  logic [31:0]                wb_data;

  // ##################################################
  dtim_req_stage u_req_stage (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req_fence (req_fence),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_wstrb (req_wstrb),
    .lk_set    (lk_set),
    .lk_bank   (lk_bank),
    .r_valid   (r_valid),
    .r_fence   (r_fence),
    .r_addr    (r_addr),
    .r_tag     (r_tag),
    .r_set     (r_set),
    .r_bank    (r_bank),
    .r_wdata   (r_wdata),
    .r_wstrb   (r_wstrb)
  );

  dtim_bank_array u_bank_array (
    .clock    (clock),
    .lk_set   (lk_set),
    .lk_bank  (lk_bank),
    .fl_rd_en (fl_rd_en),
    .fl_set   (fl_set),
    .fl_bank  (fl_bank),
    .wr_en    (wr_en),
    .wr_set   (wr_set),
    .wr_bank  (wr_bank),
    .wr_entry (wr_entry),
    .clr_en   (clr_en),
    .rd_entry (rd_entry)
  );

  dtim_lookup u_lookup (
    .r_fence   (r_fence),
    .r_addr    (r_addr),
    .r_tag     (r_tag),
    .r_wdata   (r_wdata),
    .r_wstrb   (r_wstrb),
    .rd_entry  (rd_entry),
    .cls       (cls),
    .hit_rdata (hit_rdata),
    .hit_entry (hit_entry)
  );

  dtim_flush_walker u_flush_walker (
    .clock       (clock),
    .reset       (reset),
    .flush_start (flush_start),
    .mem_ready   (mem_ready),
    .fl_rd_en    (fl_rd_en),
    .fl_set      (fl_set),
    .fl_bank     (fl_bank),
    .clr_en      (clr_en),
    .rd_entry    (rd_entry),
    .wb_valid    (wb_valid),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .flush_done  (flush_done)
  );

  dtim_fsm u_fsm (
    .clock       (clock),
    .reset       (reset),
    .r_valid     (r_valid),
    .r_addr      (r_addr),
    .r_set       (r_set),
    .r_bank      (r_bank),
    .r_tag       (r_tag),
    .r_wdata     (r_wdata),
    .r_wstrb     (r_wstrb),
    .cls         (cls),
    .hit_rdata   (hit_rdata),
    .hit_entry   (hit_entry),
    .wb_valid    (wb_valid),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .flush_done  (flush_done),
    .flush_start (flush_start),
    .wr_en       (wr_en),
    .wr_set      (wr_set),
    .wr_bank     (wr_bank),
    .wr_entry    (wr_entry),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .resp_ready  (resp_ready),
    .resp_rdata  (resp_rdata)
  );

endmodule

//--- tb/dtim_assert.sv
`timescale 1ns/1ns

module dtim_assert (
  input logic clock,
  input logic reset,
  input logic resp_ready,
  input logic mem_valid,
  input logic mem_ready
);

  int   fail_count = 0;
  logic pending;                      // Memory access awaiting mem_ready

  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
    end else if (mem_valid) begin
      pending <= 1'b1;
    end else if (mem_ready) begin
      pending <= 1'b0;
    end
  end

  // ##################################################
  resp_pulse: assert property (@(posedge clock) disable iff (!reset) resp_ready |=> !resp_ready)
  else begin
    fail_count++;
    $error("resp_ready stayed high for more than one cycle");
  end

  mem_pulse: assert property (@(posedge clock) disable iff (!reset) mem_valid |=> !mem_valid)
  else begin
    fail_count++;
    $error("mem_valid stayed high for more than one cycle");
  end

  reset_quiet: assert property (@(posedge clock) $rose(reset) |-> !resp_ready && !mem_valid)
  else begin
    fail_count++;
    $error("resp_ready or mem_valid high in the first cycle after reset");
  end

  one_outstanding: assert property (@(posedge clock) disable iff (!reset) mem_valid |-> !pending)
  else begin
    fail_count++;
    $error("mem_valid rose while a memory access was unanswered");
  end

endmodule

bind dtim dtim_assert u_dtim_assert (
  .clock      (clock),
  .reset      (reset),
  .resp_ready (resp_ready),
  .mem_valid  (mem_valid),
  .mem_ready  (mem_ready)
);

//--- tb/tb_dtim.sv
`timescale 1ns/1ns
`include "dtim_defines.svh"

module tb_dtim;

  localparam int          mem_words    = 2048;   // 8 KB backing store
  localparam int          window_words = (`DTIM_TOP_ADDR - `DTIM_BASE_ADDR) / 4;
  localparam int          num_random   = 300;
  localparam int          num_directed = 11;
  localparam int          num_requests = num_random + num_directed;
  localparam logic [31:0] seed         = 32'h06cf_3a5d;

  logic        clock = 1'b0;
  logic        reset;
  logic        req_valid;
  logic        req_fence;
  logic [31:0] req_addr;
  logic [31:0] req_wdata;
  logic [3:0]  req_wstrb;
  logic        resp_ready;
  logic [31:0] resp_rdata;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic        mem_ready;
  logic [31:0] mem_rdata;

  logic [31:0] backing [mem_words];
  logic [31:0] shadow  [mem_words];    // Expected value of every word
  logic [31:0] mem_rng;
  logic [31:0] stim_rng;
  logic [31:0] rdata;
  int          cycles;
  int          mems;
  logic [31:0] last_mem_addr;
  logic [3:0]  last_mem_wstrb;

  always #4 clock = ~clock;

  dtim u_dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] fill_word(input logic [12:0] byte_addr);
    return {3'b101, byte_addr, 3'b010, byte_addr};
  endfunction

  function automatic logic [31:0] apply_strobe(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [3:0]  strb
  );
    logic [31:0] result;
    for (int b = 0; b < 4; b++) begin
      result[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return result;
  endfunction

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want)
    else begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int got, input int want);
    assert (got == want)
    else begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, want);
      stop_with_failure();
    end
  endtask

  // ##################################################
  // One request, held until resp_ready
  task automatic access(
    input logic        fence,
    input logic [31:0] addr,
    input logic [31:0] wdata,
    input logic [3:0]  wstrb
  );
    cycles = 0;
    mems   = 0;
    @(posedge clock);
    #1;
    req_valid = 1'b1;
    req_fence = fence;
    req_addr  = addr;
    req_wdata = wdata;
    req_wstrb = wstrb;
    @(posedge clock);
    #1;
    req_valid = 1'b0;
    req_fence = 1'b0;
    do begin
      @(negedge clock);
      cycles++;
      if (mem_valid) begin
        mems++;
        last_mem_addr  = mem_addr;
        last_mem_wstrb = mem_wstrb;
        if (fence) begin
          check_value("mem_wstrb", 32'(mem_wstrb), 32'h0000_000f);
        end
      end
    end while (!resp_ready);
    rdata = resp_rdata;
    if (!fence && wstrb != 4'h0) begin
      shadow[addr[12:2]] = apply_strobe(shadow[addr[12:2]], wdata, wstrb);
    end
  endtask

  task automatic load_and_check(input logic [31:0] addr);
    access(1'b0, addr, 32'h0, 4'h0);
    check_value("resp_rdata", rdata, shadow[addr[12:2]]);
  endtask

  // ##################################################
  // Backing memory, latches at mem_valid and answers 1 to 4 cycles later
  always begin : memory_model
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    int          delay;
    @(negedge clock);
    if (reset && mem_valid) begin
      addr    = mem_addr;
      wdata   = mem_wdata;
      strb    = mem_wstrb;
      mem_rng = xorshift(mem_rng);
      delay   = 1 + int'(mem_rng[1:0]);
      @(posedge clock);
      repeat (delay - 1) @(posedge clock);
      #1;
      mem_rdata             = backing[addr[12:2]];
      backing[addr[12:2]]   = apply_strobe(backing[addr[12:2]], wdata, strb);
      mem_ready             = 1'b1;
      @(posedge clock);
      #1;
      mem_ready = 1'b0;
    end
  end

  initial begin : watchdog
    repeat (num_requests * 40 + 2000) @(posedge clock);
    $display("Timeout: the run did not finish within %0d cycles", num_requests * 40 + 2000);
    stop_with_failure();
  end

  initial begin : assertion_watch
    wait (u_dut.u_dtim_assert.fail_count != 0);
    $display("A protocol assertion on the DUT failed at %0t", $time);
    stop_with_failure();
  end

  // ##################################################
  initial begin : stimulus
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    reset     = 1'b0;
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_wstrb = '0;
    mem_ready = 1'b0;
    mem_rdata = '0;
    mem_rng   = seed;
    stim_rng  = seed;
    for (int w = 0; w < mem_words; w++) begin
      backing[w[10:0]] = fill_word({w[10:0], 2'b00});
      shadow[w[10:0]]  = fill_word({w[10:0], 2'b00});
    end
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b1;

    // Miss, then an immediate hit on the same word
    access(1'b0, 32'h0000_0040, 32'h0, 4'h0);
    check_value("resp_rdata", rdata, shadow[11'h010]);
    check_count("mem_valid pulses", mems, 1);
    access(1'b0, 32'h0000_0040, 32'h0, 4'h0);
    check_value("resp_rdata", rdata, shadow[11'h010]);
    check_count("hit latency", cycles, 1);
    check_count("mem_valid pulses", mems, 0);
    access(1'b0, 32'h0000_0040, 32'hdead_beef, 4'b0110);
    load_and_check(32'h0000_0040);

    // Same line, other tag
    access(1'b0, 32'h0000_0440, 32'h1234_5678, 4'b0101);
    check_count("mem_valid pulses", mems, 1);
    check_value("mem_addr", last_mem_addr, 32'h0000_0440);
    check_value("mem_wstrb", 32'(last_mem_wstrb), 32'h0000_0005);
    load_and_check(32'h0000_0440);
    check_count("mem_valid pulses", mems, 1);

    // Outside the window
    access(1'b0, 32'h0000_1200, 32'h0bad_f00d, 4'b1001);
    check_count("mem_valid pulses", mems, 1);
    check_value("mem_addr", last_mem_addr, 32'h0000_1200);
    check_value("mem_wstrb", 32'(last_mem_wstrb), 32'h0000_0009);
    load_and_check(32'h0000_1200);
    check_count("mem_valid pulses", mems, 1);

    for (int i = 0; i < num_random; i++) begin
      stim_rng = xorshift(stim_rng);
      addr     = {19'b0, stim_rng[12:2], 2'b00};
      stim_rng = xorshift(stim_rng);
      wdata    = stim_rng;
      stim_rng = xorshift(stim_rng);
      strb     = stim_rng[0] ? stim_rng[7:4] : 4'h0;   // About half loads
      access(1'b0, addr, wdata, strb);
      if (strb == 4'h0) begin
        check_value("resp_rdata", rdata, shadow[addr[12:2]]);
      end
    end

    access(1'b1, 32'h0, 32'h0, 4'h0);
    check_value("fence resp_rdata", rdata, 32'h0);
    for (int w = 0; w < window_words; w++) begin
      check_value($sformatf("backing[%0d]", w), backing[w[10:0]], shadow[w[10:0]]);
    end

    // Store was cleared, so these miss again
    load_and_check(32'h0000_0040);
    check_count("mem_valid pulses", mems, 1);
    load_and_check(32'h0000_0440);
    check_count("mem_valid pulses", mems, 1);

    repeat (2) @(posedge clock);
    if (u_dut.u_dtim_assert.fail_count != 0) begin
      $display("A protocol assertion on the DUT failed during the run");
      stop_with_failure();
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- project.f
+incdir+hw
hw/dtim_pkg.sv
hw/dtim_bank.sv
hw/dtim_bank_array.sv
hw/dtim_req_stage.sv
hw/dtim_lookup.sv
hw/dtim_flush_walker.sv
hw/dtim_fsm.sv
hw/dtim.sv
tb/dtim_assert.sv
tb/tb_dtim.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dtim
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hw/*.sv hw/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
